// File: source/scd_settings.svh
`ifndef SCD_SETTINGS_SVH
`define SCD_SETTINGS_SVH

// Width of FE, SC and the SCAD path including the sign and guard bits
`define SCD_EXP_W 10

// Arithmetic register width with bit 0 as the most significant bit
`define SCD_AR_W 36

// Microcode magic number field
`define SCD_MAGIC_W 9

// Number of high SC bits whose OR says the count is out of the
// single word shift range
`define SCD_SC_HIGH_W 4

// Width of the SCAD function code from the microword
`define SCD_FUNC_W 3

// Width of the SCADA, SCADB and SC source selectors
`define SCD_SEL_W 2

`endif

// File: source/scdPkg.sv
`include "scd_settings.svh"

package scdPkg;

  // Exponent or count. Bit 0 is the sign and bit 1 catches overflow
  typedef logic [0:`SCD_EXP_W-1] expT;
  typedef logic [0:`SCD_AR_W-1] arT;
  typedef logic [0:`SCD_MAGIC_W-1] magicT;

  localparam int expSignBit = 0;
  localparam int expGuardBit = 1;

  // Code order follows the microcode SCAD field
  typedef enum logic [`SCD_FUNC_W-1:0] {
    funcA,
    funcAminusBminus1,
    funcAplusB,
    funcAminus1,
    funcAplus1,
    funcAminusB,
    funcOr,
    funcAnd
  } scadFuncT;

  typedef enum logic [`SCD_SEL_W-1:0] {
    selAFe,
    selAPos,
    selAExp,
    selAMagic
  } scadaSelT;

  typedef enum logic [`SCD_SEL_W-1:0] {
    selBSc,
    selBSize,
    selBArHigh,
    selBMagic
  } scadbSelT;

  typedef enum logic [`SCD_SEL_W-1:0] {
    scHold,
    scFromFe,
    scFromScad,
    scFromAr
  } scSelT;

  // Level of the SCADA enable that lets the selected operand through
  localparam logic scadaEnActive = 1'b1;

endpackage

// File: source/scadSourceMux.sv
`timescale 1ns/10ps

// Operand selection in front of the SCAD adder
module scadSourceMux (
  input  scdPkg::scadaSelT scadaSel,
  input  logic             scadaEn,
  input  scdPkg::scadbSelT scadbSel,
  input  scdPkg::expT      fe,
  input  scdPkg::expT      sc,
  input  scdPkg::arT       ar,
  input  scdPkg::magicT    magic,
  output scdPkg::expT      scadA,
  output scdPkg::expT      scadB
);

  import scdPkg::*;

  logic [0:7] expMagnitude;
  expT posField;
  expT expField;
  expT sizeField;
  expT arHighField;
  expT magicField;
  expT scadaMux;

  // Exponent field of a floating word is stored complemented when the
  // word is negative so undo that with the AR sign
  assign expMagnitude = ar[1:8] ^ {8{ar[0]}};

  // Byte pointer position and size fields
  assign posField = expT'(ar[0:5]);
  assign sizeField = expT'(ar[6:11]);

  assign expField = expT'(expMagnitude);
  assign arHighField = expT'(signed'(ar[0:8]));

  // Magic number is a signed constant on both sides
  assign magicField = expT'(signed'(magic));

  always_comb begin
    unique case (scadaSel)
      selAFe:    scadaMux = fe;
      selAPos:   scadaMux = posField;
      selAExp:   scadaMux = expField;
      selAMagic: scadaMux = magicField;
      default:   scadaMux = fe;
    endcase
  end

  // With the enable off the adder sees zero on A so A+B passes B
  assign scadA = (scadaEn == scadaEnActive) ? scadaMux : '0;

  always_comb begin
    unique case (scadbSel)
      selBSc:     scadB = sc;
      selBSize:   scadB = sizeField;
      selBArHigh: scadB = arHighField;
      selBMagic:  scadB = magicField;
      default:    scadB = sc;
    endcase
  end

endmodule

// File: source/scadAlu.sv
`timescale 1ns/10ps

// SCAD exponent adder. The microcode picks one of eight functions
//
//   code  function
//    0    A
//    1    A-B-1
//    2    A+B
//    3    A-1
//    4    A+1
//    5    A-B
//    6    A OR B
//    7    A AND B
module scadAlu (
  input  scdPkg::scadFuncT func,
  input  scdPkg::expT      scadA,
  input  scdPkg::expT      scadB,
  output scdPkg::expT      scad,
  output logic             scadZero
);

  import scdPkg::*;

  // All results wrap at the exponent width like the slice carry chain did
  always_comb begin
    unique case (func)
      funcA: begin
        scad = scadA;
      end
      funcAminusBminus1: begin
        scad = scadA - scadB - expT'(1);
      end
      funcAplusB: begin
        scad = scadA + scadB;
      end
      funcAminus1: begin
        scad = scadA - expT'(1);
      end
      funcAplus1: begin
        scad = scadA + expT'(1);
      end
      funcAminusB: begin
        scad = scadA - scadB;
      end
      funcOr: begin
        scad = scadA | scadB;
      end
      funcAnd: begin
        scad = scadA & scadB;
      end
      default: begin
        scad = scadA;
      end
    endcase
  end

  // Feeds the microcode skip on SCAD equal to zero
  assign scadZero = (scad == '0);

endmodule

// File: source/feScRegs.sv
`timescale 1ns/10ps
`include "scd_settings.svh"

// FE and SC registers with the SC range decodes used by the shifter
module feScRegs (
  input  logic          clk,
  input  logic          rst,
  input  logic          feLoad,
  input  logic          feShift,
  input  scdPkg::scSelT scSel,
  input  scdPkg::expT   scad,
  input  scdPkg::arT    ar,
  output scdPkg::expT   fe,
  output scdPkg::expT   sc,
  output logic          feSign,
  output logic          scSign,
  output logic          scGe36,
  output logic          sc36To63
);

  import scdPkg::*;

  expT scNext;
  expT arCount;

  // Shift count from the instruction effective address.
  // Bit 18 supplies the sign for negative shifts
  assign arCount = {{2{ar[18]}}, ar[28:35]};

  // Load wins over shift
  always_ff @(posedge clk) begin
    if (rst) begin
      fe <= '0;
    end else if (feLoad) begin
      fe <= scad;
    end else if (feShift) begin
      fe <= {fe[expSignBit], fe[0:`SCD_EXP_W-2]};
    end
  end

  always_comb begin
    unique case (scSel)
      scHold:     scNext = sc;
      scFromFe:   scNext = fe;
      scFromScad: scNext = scad;
      scFromAr:   scNext = arCount;
      default:    scNext = sc;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      sc <= '0;
    end else begin
      sc <= scNext;
    end
  end

  assign feSign = fe[expSignBit];
  assign scSign = sc[expSignBit];

  // Any high bit means the count is 64 or more
  assign scGe36 = |sc[0:`SCD_SC_HIGH_W-1];

  // 32 plus at least 4 gives the 36 to 63 window
  assign sc36To63 = sc[4] & |sc[5:7];

endmodule

// File: source/pcFlags.sv
`timescale 1ns/10ps

// Sticky arithmetic flags from the PC word
module pcFlags (
  input  logic        clk,
  input  logic        rst,
  input  logic        piCycle,
  input  logic        setAdFlags,
  input  logic        adOverflow,
  input  logic        adCry0,
  input  logic        adCry1,
  input  logic        expTest,
  input  scdPkg::expT scad,
  input  logic        loadFlags,
  input  logic        clrFpd,
  input  scdPkg::arT  ar,
  output logic        ov,
  output logic        cry0,
  output logic        cry1,
  output logic        fov,
  output logic        fxu,
  output logic        divChk,
  output logic        fpd
);

  import scdPkg::*;

  logic adEn;
  logic expEn;
  logic setOv;
  logic setCry0;
  logic setCry1;
  logic setFov;
  logic setFxu;

  // An interrupt cycle must not disturb the flags of the interrupted program
  assign adEn = setAdFlags & ~piCycle;
  assign expEn = expTest & ~piCycle;

  // Exponent overflow shows up in the guard bit and underflow in the sign
  assign setOv = (adEn & adOverflow) | (expEn & scad[expGuardBit]);
  assign setCry0 = adEn & adCry0;
  assign setCry1 = adEn & adCry1;
  assign setFov = expEn & scad[expGuardBit];
  assign setFxu = expEn & scad[expSignBit];

  always_ff @(posedge clk) begin
    if (rst) begin
      ov <= 1'b0;
      cry0 <= 1'b0;
      cry1 <= 1'b0;
      fov <= 1'b0;
      fxu <= 1'b0;
      divChk <= 1'b0;
      fpd <= 1'b0;
    end else if (loadFlags) begin
      // Left half of the saved PC word holds the flags
      ov <= ar[0];
      cry0 <= ar[1];
      cry1 <= ar[2];
      fov <= ar[3];
      fpd <= ar[4];
      fxu <= ar[11];
      divChk <= ar[12];
    end else begin
      ov <= ov | setOv;
      cry0 <= cry0 | setCry0;
      cry1 <= cry1 | setCry1;
      fov <= fov | setFov;
      fxu <= fxu | setFxu;
      if (clrFpd) begin
        fpd <= 1'b0;
      end
    end
  end

endmodule

// File: source/scd.sv
`timescale 1ns/10ps

// Shift count and exponent datapath
module scd (
  input  logic             clk,
  input  logic             rst,
  input  scdPkg::scadFuncT scadFunc,
  input  scdPkg::scadaSelT scadaSel,
  input  logic             scadaEn,
  input  scdPkg::scadbSelT scadbSel,
  input  scdPkg::scSelT    scSel,
  input  logic             feLoad,
  input  logic             feShift,
  input  scdPkg::arT       ar,
  input  scdPkg::magicT    magic,
  input  logic             piCycle,
  input  logic             setAdFlags,
  input  logic             adOverflow,
  input  logic             adCry0,
  input  logic             adCry1,
  input  logic             expTest,
  input  logic             loadFlags,
  input  logic             clrFpd,
  output scdPkg::expT      scad,
  output logic             scadZero,
  output scdPkg::expT      fe,
  output scdPkg::expT      sc,
  output logic             feSign,
  output logic             scSign,
  output logic             scGe36,
  output logic             sc36To63,
  output logic             ov,
  output logic             cry0,
  output logic             cry1,
  output logic             fov,
  output logic             fxu,
  output logic             divChk,
  output logic             fpd
);

  import scdPkg::*;

  expT scadA;
  expT scadB;

  scadSourceMux sourceMux_i (
    .scadaSel(scadaSel),
    .scadaEn (scadaEn),
    .scadbSel(scadbSel),
    .fe      (fe),
    .sc      (sc),
    .ar      (ar),
    .magic   (magic),
    .scadA   (scadA),
    .scadB   (scadB)
  );

  scadAlu alu_i (
    .func    (scadFunc),
    .scadA   (scadA),
    .scadB   (scadB),
    .scad    (scad),
    .scadZero(scadZero)
  );

  // FE and SC close the loop back into the operand selectors
  feScRegs regs_i (
    .clk     (clk),
    .rst     (rst),
    .feLoad  (feLoad),
    .feShift (feShift),
    .scSel   (scSel),
    .scad    (scad),
    .ar      (ar),
    .fe      (fe),
    .sc      (sc),
    .feSign  (feSign),
    .scSign  (scSign),
    .scGe36  (scGe36),
    .sc36To63(sc36To63)
  );

  pcFlags flags_i (
    .clk       (clk),
    .rst       (rst),
    .piCycle   (piCycle),
    .setAdFlags(setAdFlags),
    .adOverflow(adOverflow),
    .adCry0    (adCry0),
    .adCry1    (adCry1),
    .expTest   (expTest),
    .scad      (scad),
    .loadFlags (loadFlags),
    .clrFpd    (clrFpd),
    .ar        (ar),
    .ov        (ov),
    .cry0      (cry0),
    .cry1      (cry1),
    .fov       (fov),
    .fxu       (fxu),
    .divChk    (divChk),
    .fpd       (fpd)
  );

endmodule

// File: sim/scd_properties.sv
`timescale 1ns/10ps

// Checks bound into the datapath top level
module scdProperties (
  input logic        clk,
  input logic        rst,
  input logic        loadFlags,
  input scdPkg::arT  ar,
  input scdPkg::expT scad,
  input logic        scadZero,
  input scdPkg::expT fe,
  input scdPkg::expT sc,
  input logic        ov
);

  zeroDetect: assert property (@(posedge clk) scadZero == (scad == '0))
    else $error("scadZero disagrees with scad %h", scad);

  resetClears: assert property (@(posedge clk) rst |=> (sc == '0 && fe == '0))
    else $error("fe or sc not zero after reset");

  // OV comes from the leftmost AR bit of the saved PC word
  ovLoad: assert property (@(posedge clk) disable iff (rst)
    loadFlags |=> ov == $past(ar[0]))
    else $error("ov not loaded from ar bit 0");

endmodule

bind scd scdProperties props_i (
  .clk      (clk),
  .rst      (rst),
  .loadFlags(loadFlags),
  .ar       (ar),
  .scad     (scad),
  .scadZero (scadZero),
  .fe       (fe),
  .sc       (sc),
  .ov       (ov)
);

// File: sim/tb_scd.sv
`timescale 1ns/10ps

module tb_scd;

  import scdPkg::*;

  localparam int clkPeriodNs = 4;
  localparam int numTests = 6;
  localparam int cyclesPerTest = 64;

  logic clk;
  logic rst;
  scadFuncT scadFunc;
  scadaSelT scadaSel;
  logic scadaEn;
  scadbSelT scadbSel;
  scSelT scSel;
  logic feLoad;
  logic feShift;
  arT ar;
  magicT magic;
  logic piCycle;
  logic setAdFlags;
  logic adOverflow;
  logic adCry0;
  logic adCry1;
  logic expTest;
  logic loadFlags;
  logic clrFpd;
  expT scad;
  logic scadZero;
  expT fe;
  expT sc;
  logic feSign;
  logic scSign;
  logic scGe36;
  logic sc36To63;
  logic ov;
  logic cry0;
  logic cry1;
  logic fov;
  logic fxu;
  logic divChk;
  logic fpd;

  int errorCount = 0;
  int testStartErrors = 0;
  logic [31:0] lcgState = 32'h549c;
  // Expected flags in the order ov, cry0, cry1, fov, fxu, divChk, fpd
  logic [0:6] model = '0;

  scd dut_i (.*);

  initial begin
    clk = 1'b0;
    forever #(clkPeriodNs / 2) clk = ~clk;
  end

  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  function automatic arT randAr();
    logic [63:0] r;
    r = {nextRand(), nextRand()};
    return r[35:0];
  endfunction

  // Counts with equal sign and guard bits so they fit the AR shift field
  function automatic expT randCount();
    logic [31:0] r;
    r = nextRand();
    return {r[24], r[24:16]};
  endfunction

  function automatic arT arWithCount(input expT v);
    arT a;
    a = randAr();
    a[18] = v[0];
    a[28:35] = v[2:9];
    return a;
  endfunction

  task automatic checkExp(input expT got, input expT want, input string what);
    if (got !== want) begin
      $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, want);
      errorCount++;
    end
  endtask

  task automatic checkFlag(input logic got, input logic want, input string what);
    if (got !== want) begin
      $display("CHECK FAILED at %0t ns: %s is %b, expected %b", $time, what, got, want);
      errorCount++;
    end
  endtask

  task automatic checkFlags(input string what);
    checkFlag(ov, model[0], {what, ": ov"});
    checkFlag(cry0, model[1], {what, ": cry0"});
    checkFlag(cry1, model[2], {what, ": cry1"});
    checkFlag(fov, model[3], {what, ": fov"});
    checkFlag(fxu, model[4], {what, ": fxu"});
    checkFlag(divChk, model[5], {what, ": divChk"});
    checkFlag(fpd, model[6], {what, ": fpd"});
  endtask

  task automatic finishTest(input string name);
    $display("%-24s %0d errors", name, errorCount - testStartErrors);
    testStartErrors = errorCount;
  endtask

  task automatic idleControls();
    scadFunc <= funcA;
    scadaSel <= selAFe;
    scadaEn <= 1'b1;
    scadbSel <= selBSc;
    scSel <= scHold;
    feLoad <= 1'b0;
    feShift <= 1'b0;
    piCycle <= 1'b0;
    setAdFlags <= 1'b0;
    adOverflow <= 1'b0;
    adCry0 <= 1'b0;
    adCry1 <= 1'b0;
    expTest <= 1'b0;
    loadFlags <= 1'b0;
    clrFpd <= 1'b0;
  endtask

  // Each microinstruction starts on a rising edge from an idle microword
  task automatic nextCycle();
    @(posedge clk);
    idleControls();
  endtask

  task automatic settle();
    @(negedge clk);
  endtask

  // SC is loaded from AR first, then FE takes it through A+B with A off
  task automatic loadFeSc(input expT feVal, input expT scVal);
    nextCycle();
    ar <= arWithCount(feVal);
    scSel <= scFromAr;
    nextCycle();
    scadaEn <= 1'b0;
    scadFunc <= funcAplusB;
    feLoad <= 1'b1;
    ar <= arWithCount(scVal);
    scSel <= scFromAr;
    nextCycle();
    settle();
    checkExp(fe, feVal, "fe load");
    checkExp(sc, scVal, "sc load");
    checkFlag(feSign, feVal[0], "feSign");
    checkFlag(scSign, scVal[0], "scSign");
  endtask

  task automatic loadFlagsFrom(input arT a);
    nextCycle();
    ar <= a;
    loadFlags <= 1'b1;
    model = {a[0], a[1], a[2], a[3], a[11], a[12], a[4]};
    nextCycle();
    settle();
    checkFlags("load from AR");
  endtask

  task automatic expTestWith(input magicT m, input logic pi);
    expT s;
    s = {m[0], m};
    nextCycle();
    magic <= m;
    scadaSel <= selAMagic;
    expTest <= 1'b1;
    piCycle <= pi;
    setAdFlags <= pi;
    adOverflow <= 1'b1;
    adCry0 <= 1'b1;
    adCry1 <= 1'b1;
    if (!pi) begin
      // Guard bit means exponent overflow and the sign bit underflow
      model[0] = model[0] | s[1];
      model[3] = model[3] | s[1];
      model[4] = model[4] | s[0];
    end
    nextCycle();
    settle();
    checkFlags(pi ? "interrupt cycle" : "exponent test");
  endtask

  task automatic adderTest();
    expT a;
    expT b;
    expT want;
    int f;
    for (f = 0; f < 8; f++) begin
      a = randCount();
      b = randCount();
      loadFeSc(a, b);
      nextCycle();
      scadFunc <= scadFuncT'(f);
      settle();
      case (f)
        0: want = a;
        1: want = expT'((int'(a) - int'(b) - 1) & 1023);
        2: want = expT'((int'(a) + int'(b)) & 1023);
        3: want = expT'((int'(a) - 1) & 1023);
        4: want = expT'((int'(a) + 1) & 1023);
        5: want = expT'((int'(a) - int'(b)) & 1023);
        6: want = a | b;
        default: want = a & b;
      endcase
      checkExp(scad, want, $sformatf("scad function %0d", f));
    end
    loadFeSc(a, a);
    nextCycle();
    scadFunc <= funcAminusB;
    settle();
    checkExp(scad, '0, "scad of A-B with A equal to B");
    checkFlag(scadZero, 1'b1, "scadZero");
    finishTest("adder functions");
  endtask

  task automatic selectorTest();
    arT a;
    magicT m;
    expT feVal;
    expT scVal;
    expT wantA [4];
    expT wantB [4];
    int s;
    feVal = randCount();
    scVal = randCount();
    loadFeSc(feVal, scVal);
    a = randAr();
    m = magicT'(nextRand() >> 16);
    wantA[0] = feVal;
    wantA[1] = {4'b0000, a[0:5]};
    wantA[2] = {2'b00, a[1:8] ^ {8{a[0]}}};
    wantA[3] = {m[0], m};
    wantB[0] = scVal;
    wantB[1] = {4'b0000, a[6:11]};
    wantB[2] = {a[0], a[0:8]};
    wantB[3] = {m[0], m};
    nextCycle();
    ar <= a;
    magic <= m;
    for (s = 0; s < 4; s++) begin
      nextCycle();
      scadaSel <= scadaSelT'(s);
      settle();
      checkExp(scad, wantA[s], $sformatf("scada select %0d", s));
      nextCycle();
      scadaEn <= 1'b0;
      scadFunc <= funcAplusB;
      scadbSel <= scadbSelT'(s);
      settle();
      checkExp(scad, wantB[s], $sformatf("scadb select %0d", s));
    end
    finishTest("operand selectors");
  endtask

  task automatic feScTest();
    expT v;
    arT a;
    expT counts [4];
    logic wantGe [4];
    logic wantWin [4];
    int i;
    counts = '{10'd35, 10'd36, 10'd40, 10'd64};
    wantGe = '{1'b0, 1'b0, 1'b0, 1'b1};
    wantWin = '{1'b0, 1'b1, 1'b1, 1'b0};
    for (i = 0; i < 2; i++) begin
      v = (i == 0) ? 10'h3C6 : 10'h0B4;
      loadFeSc(v, randCount());
      nextCycle();
      feShift <= 1'b1;
      nextCycle();
      settle();
      checkExp(fe, expT'($signed(v) >>> 1), "fe arithmetic shift");
    end
    v = randCount();
    loadFeSc(v, 10'h015);
    nextCycle();
    settle();
    checkExp(sc, 10'h015, "sc hold");
    nextCycle();
    scSel <= scFromFe;
    nextCycle();
    settle();
    checkExp(sc, v, "sc from fe");
    nextCycle();
    scadFunc <= funcAplus1;
    scSel <= scFromScad;
    nextCycle();
    settle();
    checkExp(sc, expT'((int'(v) + 1) & 1023), "sc from scad");
    a = randAr();
    nextCycle();
    ar <= a;
    scSel <= scFromAr;
    nextCycle();
    settle();
    checkExp(sc, {a[18], a[18], a[28:35]}, "sc from ar");
    for (i = 0; i < 4; i++) begin
      loadFeSc(randCount(), counts[i]);
      checkFlag(scGe36, wantGe[i], $sformatf("scGe36 at %0d", counts[i]));
      checkFlag(sc36To63, wantWin[i], $sformatf("sc36To63 at %0d", counts[i]));
    end
    finishTest("fe and sc registers");
  endtask

  task automatic flagTest();
    logic [31:0] r;
    arT a;
    int i;
    loadFlagsFrom('0);
    for (i = 0; i < 4; i++) begin
      r = nextRand() >> 16;
      nextCycle();
      setAdFlags <= 1'b1;
      adOverflow <= r[0];
      adCry0 <= r[1];
      adCry1 <= r[2];
      model[0] = model[0] | r[0];
      model[1] = model[1] | r[1];
      model[2] = model[2] | r[2];
      nextCycle();
      settle();
      checkFlags("set from adder");
    end
    // Nothing driven for a cycle so every flag must hold
    nextCycle();
    settle();
    checkFlags("sticky hold");
    loadFlagsFrom(randAr());
    a = randAr();
    a[4] = 1'b1;
    loadFlagsFrom(a);
    nextCycle();
    clrFpd <= 1'b1;
    model[6] = 1'b0;
    nextCycle();
    settle();
    checkFlags("clear fpd");
    finishTest("flags from adder and AR");
  endtask

  task automatic exponentTest();
    loadFlagsFrom('0);
    expTestWith(9'h05A, 1'b0);
    expTestWith(9'h1A5, 1'b0);
    loadFlagsFrom('0);
    expTestWith(9'h1A5, 1'b1);
    finishTest("exponent test and PI");
  endtask

  task automatic resetTest();
    loadFeSc(10'h02A, 10'h3D3);
    loadFlagsFrom('1);
    nextCycle();
    rst <= 1'b1;
    nextCycle();
    rst <= 1'b0;
    settle();
    model = '0;
    checkExp(fe, '0, "fe after reset");
    checkExp(sc, '0, "sc after reset");
    checkFlag(feSign, 1'b0, "feSign after reset");
    checkFlag(scSign, 1'b0, "scSign after reset");
    checkFlags("after reset");
    finishTest("reset");
  endtask

  initial begin
    rst <= 1'b1;
    ar <= '0;
    magic <= '0;
    idleControls();
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    adderTest();
    selectorTest();
    feScTest();
    flagTest();
    exponentTest();
    resetTest();
    $display("Summary: %0d tests run, %0d errors", numTests, errorCount);
    if (errorCount == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

  initial begin
    #(numTests * cyclesPerTest * clkPeriodNs);
    $display("Timeout: the tests did not finish within %0d ns",
             numTests * cyclesPerTest * clkPeriodNs);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

// File: vlog.f
+incdir+source
source/scdPkg.sv
source/scadSourceMux.sv
source/scadAlu.sv
source/feScRegs.sv
source/pcFlags.sv
source/scd.sv
sim/scd_properties.sv
sim/tb_scd.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator

verilator --binary --timing --assert -j 0 -f vlog.f --top-module tb_scd -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_scd > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "NO ERRORS" sim.log; then
  exit 0
fi
echo "Simulation did not pass, see sim.log"
exit 1
